// File: axi_bridge.f
rtl/axi_bridge_pkg.sv
rtl/mem_rd_if.sv
rtl/mem_wr_if.sv
rtl/read_channel.sv
rtl/write_buffer.sv
rtl/axi_bridge.sv
tb/axi_bridge_checker.sv
tb/axi_bridge_tb.sv

// File: rtl/axi_bridge.sv
`timescale 1ns/1ps

module axi_bridge import axi_bridge_pkg::*; (
  input  logic                         aclk,
  input  logic                         arst_n,
  input  logic                         inst_rd_req,
  input  logic [req_type_w-1:0]        inst_rd_type,
  input  logic [addr_w-1:0]            inst_rd_addr,
  output logic                         inst_rd_rdy,
  output logic                         inst_ret_valid,
  output logic                         inst_ret_last,
  output logic [data_w-1:0]            inst_ret_data,
  input  logic                         data_rd_req,
  input  logic [req_type_w-1:0]        data_rd_type,
  input  logic [addr_w-1:0]            data_rd_addr,
  output logic                         data_rd_rdy,
  output logic                         data_ret_valid,
  output logic                         data_ret_last,
  output logic [data_w-1:0]            data_ret_data,
  input  logic                         data_wr_req,
  input  logic [req_type_w-1:0]        data_wr_type,
  input  logic [addr_w-1:0]            data_wr_addr,
  input  logic [strb_w-1:0]            data_wr_wstrb,
  input  logic [line_words*data_w-1:0] data_wr_data,
  output logic                         data_wr_rdy,
  output logic [id_w-1:0]              arid,
  output logic [addr_w-1:0]            araddr,
  output logic [7:0]                   arlen,
  output logic [2:0]                   arsize,
  output logic [1:0]                   arburst,
  output logic                         arvalid,
  input  logic                         arready,
  input  logic [id_w-1:0]              rid,
  input  logic [data_w-1:0]            rdata,
  input  logic                         rlast,
  input  logic                         rvalid,
  output logic                         rready,
  output logic [id_w-1:0]              awid,
  output logic [addr_w-1:0]            awaddr,
  output logic [7:0]                   awlen,
  output logic [2:0]                   awsize,
  output logic [1:0]                   awburst,
  output logic                         awvalid,
  input  logic                         awready,
  output logic [data_w-1:0]            wdata,
  output logic [strb_w-1:0]            wstrb,
  output logic                         wlast,
  output logic                         wvalid,
  input  logic                         wready,
  input  logic [id_w-1:0]              bid,
  input  logic                         bvalid,
  output logic                         bready,
  output logic                         write_buffer_empty
);

  mem_rd_if inst_rd ();
  mem_rd_if data_rd ();
  mem_wr_if data_wr ();

  // instruction read port
  assign inst_rd.rd_req  = inst_rd_req;
  assign inst_rd.rd_type = inst_rd_type;
  assign inst_rd.rd_addr = inst_rd_addr;
  assign inst_rd_rdy     = inst_rd.rd_rdy;
  assign inst_ret_valid  = inst_rd.ret_valid;
  assign inst_ret_last   = inst_rd.ret_last;
  assign inst_ret_data   = inst_rd.ret_data;

  // data read port
  assign data_rd.rd_req  = data_rd_req;
  assign data_rd.rd_type = data_rd_type;
  assign data_rd.rd_addr = data_rd_addr;
  assign data_rd_rdy     = data_rd.rd_rdy;
  assign data_ret_valid  = data_rd.ret_valid;
  assign data_ret_last   = data_rd.ret_last;
  assign data_ret_data   = data_rd.ret_data;

  // data write port
  assign data_wr.wr_req   = data_wr_req;
  assign data_wr.wr_type  = data_wr_type;
  assign data_wr.wr_addr  = data_wr_addr;
  assign data_wr.wr_wstrb = data_wr_wstrb;
  assign data_wr.wr_data  = data_wr_data;
  assign data_wr_rdy      = data_wr.wr_rdy;

  read_channel read_channel_i (
    .aclk               (aclk),
    .arst_n             (arst_n),
    .inst_port          (inst_rd.bridge),
    .data_port          (data_rd.bridge),
    .write_buffer_empty (write_buffer_empty),
    .arid               (arid),
    .araddr             (araddr),
    .arlen              (arlen),
    .arsize             (arsize),
    .arburst            (arburst),
    .arvalid            (arvalid),
    .arready            (arready),
    .rid                (rid),
    .rdata              (rdata),
    .rlast              (rlast),
    .rvalid             (rvalid),
    .rready             (rready)
  );

  write_buffer write_buffer_i (
    .aclk               (aclk),
    .arst_n             (arst_n),
    .wr_port            (data_wr.bridge),
    .write_buffer_empty (write_buffer_empty),
    .awid               (awid),
    .awaddr             (awaddr),
    .awlen              (awlen),
    .awsize             (awsize),
    .awburst            (awburst),
    .awvalid            (awvalid),
    .awready            (awready),
    .wdata              (wdata),
    .wstrb              (wstrb),
    .wlast              (wlast),
    .wvalid             (wvalid),
    .wready             (wready),
    .bid                (bid),
    .bvalid             (bvalid),
    .bready             (bready)
  );

endmodule

// File: rtl/axi_bridge_pkg.sv
package axi_bridge_pkg;

  localparam int addr_w     = 32;
  localparam int data_w     = 32;
  localparam int line_words = 4;
  localparam int strb_w     = 4;
  localparam int req_type_w = 3;
  localparam int id_w       = 4;

  // cache request codes
  localparam logic [req_type_w-1:0] req_word = 3'd2;
  localparam logic [req_type_w-1:0] req_line = 3'd4;

  // instruction and data traffic split by id
  localparam logic [id_w-1:0] id_inst = 4'd0;
  localparam logic [id_w-1:0] id_data = 4'd1;

  localparam logic [7:0] len_line   = 8'd3;
  localparam logic [2:0] size_word  = 3'd2;
  localparam logic [1:0] burst_incr = 2'd1;

  // flat line from the cache, or one word per write beat
  typedef union packed {
    logic [line_words*data_w-1:0]      flat;
    logic [line_words-1:0][data_w-1:0] words;
  } cache_line_u;

endpackage

// File: rtl/mem_rd_if.sv
`timescale 1ns/1ps

interface mem_rd_if import axi_bridge_pkg::*; ();

  logic                  rd_req;
  logic [req_type_w-1:0] rd_type;
  logic [addr_w-1:0]     rd_addr;
  logic                  rd_rdy;
  logic                  ret_valid;
  logic                  ret_last;
  logic [data_w-1:0]     ret_data;

  modport requester (
    output rd_req, rd_type, rd_addr,
    input  rd_rdy, ret_valid, ret_last, ret_data
  );

  // return words have no back-pressure
  modport bridge (
    input  rd_req, rd_type, rd_addr,
    output rd_rdy, ret_valid, ret_last, ret_data
  );

endinterface

// File: rtl/mem_wr_if.sv
`timescale 1ns/1ps

interface mem_wr_if import axi_bridge_pkg::*; ();

  logic                         wr_req;
  logic [req_type_w-1:0]        wr_type;
  logic [addr_w-1:0]            wr_addr;
  logic [strb_w-1:0]            wr_wstrb;
  logic [line_words*data_w-1:0] wr_data;
  logic                         wr_rdy;

  modport requester (
    output wr_req, wr_type, wr_addr, wr_wstrb, wr_data,
    input  wr_rdy
  );

  modport bridge (
    input  wr_req, wr_type, wr_addr, wr_wstrb, wr_data,
    output wr_rdy
  );

endinterface

// File: rtl/read_channel.sv
`timescale 1ns/1ps

module read_channel import axi_bridge_pkg::*; (
  input  logic              aclk,
  input  logic              arst_n,
  mem_rd_if.bridge          inst_port,
  mem_rd_if.bridge          data_port,
  input  logic              write_buffer_empty,
  output logic [id_w-1:0]   arid,
  output logic [addr_w-1:0] araddr,
  output logic [7:0]        arlen,
  output logic [2:0]        arsize,
  output logic [1:0]        arburst,
  output logic              arvalid,
  input  logic              arready,
  input  logic [id_w-1:0]   rid,
  input  logic [data_w-1:0] rdata,
  input  logic              rlast,
  input  logic              rvalid,
  output logic              rready
);

  // idle when !busy_q, address while arvalid_q, data otherwise
  logic                  busy_q;
  logic                  arvalid_q;
  logic [addr_w-1:0]     addr_q;
  logic [req_type_w-1:0] type_q;
  logic [id_w-1:0]       id_q;

  logic data_ok;
  logic data_grant;
  logic inst_grant;
  logic inst_hit;
  logic data_hit;

  // data reads wait for the write buffer to drain
  assign data_ok    = data_port.rd_req && write_buffer_empty;
  assign data_grant = !busy_q && data_ok;
  assign inst_grant = !busy_q && !data_ok && inst_port.rd_req;

  assign data_port.rd_rdy = !busy_q && write_buffer_empty;
  assign inst_port.rd_rdy = !busy_q && !data_ok;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      busy_q    <= 1'b0;
      arvalid_q <= 1'b0;
    end else begin
      if (data_grant || inst_grant) begin
        busy_q    <= 1'b1;
        arvalid_q <= 1'b1;
      end else if (arvalid_q && arready) begin
        arvalid_q <= 1'b0;
      end else if (rvalid && rready && rlast) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (data_grant) begin
      addr_q <= data_port.rd_addr;
      type_q <= data_port.rd_type;
      id_q   <= id_data;
    end else if (inst_grant) begin
      addr_q <= inst_port.rd_addr;
      type_q <= inst_port.rd_type;
      id_q   <= id_inst;
    end
  end

  assign arvalid = arvalid_q;
  assign arid    = id_q;
  assign araddr  = addr_q;
  assign arlen   = (type_q == req_line) ? len_line : 8'd0;
  assign arsize  = size_word;
  assign arburst = burst_incr;

  assign rready = busy_q && !arvalid_q;

  // steer each beat by its id
  assign inst_hit = rvalid && rready && (rid == id_inst);
  assign data_hit = rvalid && rready && (rid == id_data);

  assign inst_port.ret_valid = inst_hit;
  assign inst_port.ret_last  = inst_hit && rlast;
  assign inst_port.ret_data  = rdata;
  assign data_port.ret_valid = data_hit;
  assign data_port.ret_last  = data_hit && rlast;
  assign data_port.ret_data  = rdata;

endmodule

// File: rtl/write_buffer.sv
`timescale 1ns/1ps

module write_buffer import axi_bridge_pkg::*; (
  input  logic              aclk,
  input  logic              arst_n,
  mem_wr_if.bridge          wr_port,
  output logic              write_buffer_empty,
  output logic [id_w-1:0]   awid,
  output logic [addr_w-1:0] awaddr,
  output logic [7:0]        awlen,
  output logic [2:0]        awsize,
  output logic [1:0]        awburst,
  output logic              awvalid,
  input  logic              awready,
  output logic [data_w-1:0] wdata,
  output logic [strb_w-1:0] wstrb,
  output logic              wlast,
  output logic              wvalid,
  input  logic              wready,
  input  logic [id_w-1:0]   bid,
  input  logic              bvalid,
  output logic              bready
);

  logic full_q;
  logic awvalid_q;
  logic wvalid_q;
  logic bready_q;
  logic [$clog2(line_words)-1:0] beat_q;

  logic [addr_w-1:0]     addr_q;
  logic [req_type_w-1:0] type_q;
  logic [strb_w-1:0]     strb_q;
  cache_line_u           line_q;

  logic accept;
  logic single;
  logic b_done;

  assign write_buffer_empty = !full_q;
  assign wr_port.wr_rdy     = !full_q;
  assign accept             = wr_port.wr_req && !full_q;

  assign single = (type_q == req_word);
  assign b_done = bvalid && bready_q && (bid == id_data);

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      full_q    <= 1'b0;
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
      bready_q  <= 1'b0;
      beat_q    <= '0;
    end else begin
      if (accept) begin
        full_q    <= 1'b1;
        awvalid_q <= 1'b1;
        beat_q    <= '0;
      end
      if (awvalid_q && awready) begin
        awvalid_q <= 1'b0;
        wvalid_q  <= 1'b1;
      end
      if (wvalid_q && wready) begin
        if (wlast) begin
          wvalid_q <= 1'b0;
          bready_q <= 1'b1;
        end else begin
          beat_q <= beat_q + 1'b1;
        end
      end
      if (b_done) begin
        bready_q <= 1'b0;
        full_q   <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (accept) begin
      addr_q      <= wr_port.wr_addr;
      type_q      <= wr_port.wr_type;
      strb_q      <= wr_port.wr_wstrb;
      line_q.flat <= wr_port.wr_data;
    end
  end

  assign awvalid = awvalid_q;
  assign awid    = id_data;
  assign awaddr  = addr_q;
  assign awlen   = single ? 8'd0 : len_line;
  assign awsize  = size_word;
  assign awburst = burst_incr;

  // a word write carries its data in the lowest word
  assign wvalid = wvalid_q;
  assign wdata  = line_q.words[beat_q];
  assign wstrb  = strb_q;
  // counter all ones marks the fourth beat
  assign wlast  = single || (&beat_q);

  assign bready = bready_q;

endmodule

// File: run.sh
#!/bin/sh
# build and run the axi_bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module axi_bridge_tb \
  -f axi_bridge.f

out=$(./obj_dir/Vaxi_bridge_tb)
echo "$out"

# fails the script unless the pass line is present
echo "$out" | grep -qx "TEST PASS"

// File: tb/axi_bridge_checker.sv
`timescale 1ns/1ps

module axi_bridge_checker import axi_bridge_pkg::*; (
  input logic              aclk,
  input logic              arst_n,
  input logic              arvalid,
  input logic              arready,
  input logic [id_w-1:0]   arid,
  input logic [addr_w-1:0] araddr,
  input logic [7:0]        arlen,
  input logic              awvalid,
  input logic              awready,
  input logic [addr_w-1:0] awaddr,
  input logic [7:0]        awlen,
  input logic              wvalid,
  input logic              wready,
  input logic [data_w-1:0] wdata,
  input logic [strb_w-1:0] wstrb,
  input logic              wlast,
  input logic              rvalid,
  input logic              inst_ret_valid,
  input logic              data_ret_valid
);

  // valid holds with stable payload until ready
  ar_hold: assert property (@(posedge aclk) disable iff (!arst_n)
    arvalid && !arready |=> arvalid && $stable({arid, araddr, arlen}))
    else $error("arvalid dropped or AR payload changed before arready");

  aw_hold: assert property (@(posedge aclk) disable iff (!arst_n)
    awvalid && !awready |=> awvalid && $stable({awaddr, awlen}))
    else $error("awvalid dropped or AW payload changed before awready");

  w_hold: assert property (@(posedge aclk) disable iff (!arst_n)
    wvalid && !wready |=> wvalid && $stable({wdata, wstrb, wlast}))
    else $error("wvalid dropped or W payload changed before wready");

  // returned words only come straight from an R beat
  ret_with_r: assert property (@(posedge aclk) disable iff (!arst_n)
    (inst_ret_valid || data_ret_valid) |-> rvalid)
    else $error("ret_valid raised without rvalid");

endmodule

// File: tb/axi_bridge_tb.sv
`timescale 1ns/1ps

module axi_bridge_tb import axi_bridge_pkg::*; ();

  localparam int op_inst  = 0;
  localparam int op_data  = 1;
  localparam int op_both  = 2;
  localparam int op_write = 3;
  localparam int timeout  = 50;
  localparam int n_rows   = 7;

  typedef struct {
    int                           op;
    logic [req_type_w-1:0]        typ;
    logic [addr_w-1:0]            addr;
    logic [line_words*data_w-1:0] line;
    logic [strb_w-1:0]            strb;
  } row_t;

  logic aclk, arst_n;
  logic inst_rd_req, inst_rd_rdy, inst_ret_valid, inst_ret_last;
  logic data_rd_req, data_rd_rdy, data_ret_valid, data_ret_last;
  logic data_wr_req, data_wr_rdy, write_buffer_empty;
  logic [req_type_w-1:0] inst_rd_type, data_rd_type, data_wr_type;
  logic [addr_w-1:0] inst_rd_addr, data_rd_addr, data_wr_addr, araddr, awaddr;
  logic [data_w-1:0] inst_ret_data, data_ret_data, rdata, wdata;
  logic [strb_w-1:0] data_wr_wstrb, wstrb;
  logic [line_words*data_w-1:0] data_wr_data;
  logic [id_w-1:0] arid, rid, awid, bid;
  logic [7:0] arlen, awlen;
  logic [2:0] arsize, awsize;
  logic [1:0] arburst, awburst;
  logic arvalid, arready, rlast, rvalid, rready;
  logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;

  logic [data_w-1:0] mem [64];
  logic [data_w-1:0] exp_mem [64];
  logic [43:0] exp_ar[$], got_ar[$], exp_aw[$], got_aw[$];
  logic [36:0] exp_w[$], got_w[$];
  logic [31:0] seed = 32'd76745;
  int errors;
  int accepts;
  int b_count;
  row_t rows [n_rows];

  axi_bridge dut_i (.*);

  bind axi_bridge axi_bridge_checker checker_i (.*);

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  // upper lcg bits give a 0 to 3 cycle delay
  function automatic logic [1:0] next_delay();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed[17:16];
  endfunction

  function automatic logic [data_w-1:0] fill_word(input int idx);
    return 32'hc0de_0000 ^ (idx * 32'h0101_0103);
  endfunction

  function automatic logic [data_w-1:0] merge_bytes(input logic [data_w-1:0] old_w,
      input logic [data_w-1:0] new_w, input logic [strb_w-1:0] strb);
    logic [data_w-1:0] res;
    res = old_w;
    for (int b = 0; b < strb_w; b++) begin
      if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
      input string msg);
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH at %0t ns: %s, got %0h, expected %0h", $time, msg, actual, expected);
    end
  endtask

  task automatic check_beat(input logic [data_w-1:0] data, input logic last,
      input logic [5:0] idx, input logic exp_last, input string msg);
    check_value(64'(data), 64'(exp_mem[idx]), {msg, " data"});
    check_value(64'(last), 64'(exp_last), {msg, " last"});
  endtask

  task automatic compare_logs();
    logic [43:0] a;
    logic [43:0] b;
    logic [36:0] c;
    logic [36:0] d;
    while (exp_ar.size() > 0 && got_ar.size() > 0) begin
      a = got_ar.pop_front();
      b = exp_ar.pop_front();
      check_value(64'(a), 64'(b), "AR id, len and address");
    end
    while (exp_aw.size() > 0 && got_aw.size() > 0) begin
      a = got_aw.pop_front();
      b = exp_aw.pop_front();
      check_value(64'(a), 64'(b), "AW id, len and address");
    end
    while (exp_w.size() > 0 && got_w.size() > 0) begin
      c = got_w.pop_front();
      d = exp_w.pop_front();
      check_value(64'(c), 64'(d), "W last, strobe and data");
    end
  endtask

  // starts and ends 5 ns after a rising edge
  task automatic read_ports(input logic use_inst, input logic use_data, input row_t r);
    logic acc_i;
    logic acc_d;
    logic [addr_w-1:0] daddr;
    int nbeats;
    int inst_beats;
    int data_beats;
    int idle;
    nbeats = (r.typ == req_line) ? line_words : 1;
    daddr = use_inst ? r.addr + 32'h20 : r.addr;
    inst_beats = use_inst ? 0 : nbeats;
    data_beats = use_data ? 0 : nbeats;
    // data has priority, so its AR comes first
    if (use_data) exp_ar.push_back({id_data, (r.typ == req_line) ? 8'd3 : 8'd0, daddr});
    if (use_inst) exp_ar.push_back({id_inst, (r.typ == req_line) ? 8'd3 : 8'd0, r.addr});
    inst_rd_req = use_inst;
    inst_rd_type = r.typ;
    inst_rd_addr = r.addr;
    data_rd_req = use_data;
    data_rd_type = r.typ;
    data_rd_addr = daddr;
    idle = 0;
    while ((inst_rd_req || data_rd_req || inst_beats < nbeats || data_beats < nbeats)
        && idle < timeout) begin
      @(negedge aclk);
      idle++;
      acc_i = inst_rd_req && inst_rd_rdy;
      acc_d = data_rd_req && data_rd_rdy;
      if (inst_ret_valid) begin
        check_beat(inst_ret_data, inst_ret_last, r.addr[7:2] + 6'(inst_beats),
                   inst_beats == nbeats - 1, "inst return");
        inst_beats++;
        idle = 0;
      end
      if (data_ret_valid) begin
        check_beat(data_ret_data, data_ret_last, daddr[7:2] + 6'(data_beats),
                   data_beats == nbeats - 1, "data return");
        data_beats++;
        idle = 0;
      end
      @(posedge aclk);
      #5;
      if (acc_i || acc_d) idle = 0;
      if (acc_i) inst_rd_req = 1'b0;
      if (acc_d) data_rd_req = 1'b0;
    end
    if (idle >= timeout) begin
      errors++;
      $display("timeout: read at address %0h not finished after %0d idle cycles", r.addr, idle);
      inst_rd_req = 1'b0;
      data_rd_req = 1'b0;
    end
  endtask

  // returns once the write is accepted, without waiting for B
  task automatic write_line(input row_t r);
    logic acc;
    logic [5:0] base;
    int nbeats;
    int idle;
    nbeats = (r.typ == req_line) ? line_words : 1;
    base = r.addr[7:2];
    exp_aw.push_back({id_data, (r.typ == req_line) ? 8'd3 : 8'd0, r.addr});
    for (int k = 0; k < nbeats; k++) begin
      exp_w.push_back({k == nbeats - 1, r.strb, r.line[32*k +: 32]});
      exp_mem[base + 6'(k)] = merge_bytes(exp_mem[base + 6'(k)], r.line[32*k +: 32], r.strb);
    end
    data_wr_req = 1'b1;
    data_wr_type = r.typ;
    data_wr_addr = r.addr;
    data_wr_wstrb = r.strb;
    data_wr_data = r.line;
    acc = 1'b0;
    idle = 0;
    while (!acc && idle < timeout) begin
      @(negedge aclk);
      acc = data_wr_rdy;
      idle++;
      @(posedge aclk);
      #5;
    end
    data_wr_req = 1'b0;
    if (acc) begin
      accepts++;
    end else begin
      errors++;
      $display("timeout: write at address %0h was never accepted", r.addr);
    end
  endtask

  // AXI slave memory samples at the falling edge and drives after the rising edge
  initial begin : axi_slave
    logic ar_hs, r_hs, aw_hs, w_hs, b_hs, pending, rd_active, b_pending;
    logic [43:0] ar_snap;
    logic [36:0] w_snap;
    logic [1:0] ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt;
    logic [5:0] rd_base, wr_base, wr_beat;
    logic [7:0] rd_beat, rd_len;
    logic [id_w-1:0] rd_id;
    for (int i = 0; i < 64; i++) mem[i] = fill_word(i);
    arready = 1'b0;
    rvalid = 1'b0;
    rlast = 1'b0;
    rid = '0;
    rdata = '0;
    awready = 1'b0;
    wready = 1'b0;
    bvalid = 1'b0;
    bid = '0;
    b_count = 0;
    rd_active = 1'b0;
    b_pending = 1'b0;
    rd_base = '0;
    rd_beat = '0;
    rd_len = '0;
    rd_id = '0;
    wr_base = '0;
    wr_beat = '0;
    ar_cnt = next_delay();
    r_cnt = next_delay();
    aw_cnt = next_delay();
    w_cnt = next_delay();
    b_cnt = next_delay();
    forever begin
      @(negedge aclk);
      ar_hs = arvalid && arready;
      r_hs = rvalid && rready;
      aw_hs = awvalid && awready;
      w_hs = wvalid && wready;
      b_hs = bvalid && bready;
      ar_snap = {arid, arlen, araddr};
      w_snap = {wlast, wstrb, wdata};
      pending = (accepts != b_count);
      if (arst_n) begin
        check_value(64'(write_buffer_empty), 64'(!pending), "write_buffer_empty");
        if (pending && arvalid) check_value(64'(arid), 64'(id_inst), "arid during write");
        if (arvalid) check_value(64'({arsize, arburst}), 64'({3'd2, 2'd1}), "AR size and burst");
        if (awvalid) check_value(64'({awsize, awburst}), 64'({3'd2, 2'd1}), "AW size and burst");
      end
      @(posedge aclk);
      #5;
      if (ar_hs) begin
        got_ar.push_back(ar_snap);
        arready = 1'b0;
        rd_active = 1'b1;
        rd_id = ar_snap[43:40];
        rd_len = ar_snap[39:32];
        rd_base = ar_snap[7:2];
        rd_beat = '0;
        ar_cnt = next_delay();
      end else if (arvalid && !arready) begin
        arready = (ar_cnt == 2'd0);
        ar_cnt = ar_cnt - 2'd1;
      end
      if (r_hs) begin
        rvalid = 1'b0;
        rlast = 1'b0;
        if (rd_beat == rd_len) rd_active = 1'b0;
        rd_beat = rd_beat + 8'd1;
        r_cnt = next_delay();
      end else if (rd_active && !rvalid) begin
        if (r_cnt == 2'd0) begin
          rvalid = 1'b1;
          rid = rd_id;
          rdata = mem[rd_base + rd_beat[5:0]];
          rlast = (rd_beat == rd_len);
        end
        r_cnt = r_cnt - 2'd1;
      end
      if (aw_hs) begin
        got_aw.push_back({awid, awlen, awaddr});
        awready = 1'b0;
        wr_base = awaddr[7:2];
        wr_beat = '0;
        aw_cnt = next_delay();
      end else if (awvalid && !awready) begin
        awready = (aw_cnt == 2'd0);
        aw_cnt = aw_cnt - 2'd1;
      end
      if (w_hs) begin
        got_w.push_back(w_snap);
        mem[wr_base + wr_beat] = merge_bytes(mem[wr_base + wr_beat], w_snap[31:0], w_snap[35:32]);
        wr_beat = wr_beat + 6'd1;
        wready = 1'b0;
        if (w_snap[36]) b_pending = 1'b1;
        w_cnt = next_delay();
      end else if (wvalid && !wready) begin
        wready = (w_cnt == 2'd0);
        w_cnt = w_cnt - 2'd1;
      end
      if (b_hs) begin
        bvalid = 1'b0;
        b_pending = 1'b0;
        b_count++;
        b_cnt = next_delay();
      end else if (b_pending && !bvalid) begin
        bvalid = (b_cnt == 2'd0);
        bid = id_data;
        b_cnt = b_cnt - 2'd1;
      end
    end
  end

  initial begin
    errors = 0;
    accepts = 0;
    arst_n = 1'b0;
    inst_rd_req = 1'b0;
    inst_rd_type = '0;
    inst_rd_addr = '0;
    data_rd_req = 1'b0;
    data_rd_type = '0;
    data_rd_addr = '0;
    data_wr_req = 1'b0;
    data_wr_type = '0;
    data_wr_addr = '0;
    data_wr_wstrb = '0;
    data_wr_data = '0;
    for (int i = 0; i < 64; i++) exp_mem[i] = fill_word(i);
    rows[0] = '{op_inst, req_line, 32'h0000_0040, 128'd0, 4'd0};
    rows[1] = '{op_data, req_word, 32'h0000_0084, 128'd0, 4'd0};
    rows[2] = '{op_both, req_line, 32'h0000_0080, 128'd0, 4'd0};
    rows[3] = '{op_write, req_line, 32'h0000_0010,
                128'hdead_0003_beef_0002_cafe_0001_f00d_0000, 4'hf};
    rows[4] = '{op_data, req_line, 32'h0000_0010, 128'd0, 4'd0};
    // partial strobe write, then a read of the same word at once
    rows[5] = '{op_write, req_word, 32'h0000_0024, 128'h1234_5678, 4'b0101};
    rows[6] = '{op_data, req_word, 32'h0000_0024, 128'd0, 4'd0};
    repeat (2) @(posedge aclk);
    #5;
    arst_n = 1'b1;
    for (int i = 0; i < n_rows; i++) begin
      case (rows[i].op)
        op_write: write_line(rows[i]);
        op_both:  read_ports(1'b1, 1'b1, rows[i]);
        op_inst:  read_ports(1'b1, 1'b0, rows[i]);
        default:  read_ports(1'b0, 1'b1, rows[i]);
      endcase
      compare_logs();
    end
    check_value(64'(exp_ar.size() + exp_aw.size() + exp_w.size()), 64'd0, "AXI beats missing");
    check_value(64'(got_ar.size() + got_aw.size() + got_w.size()), 64'd0, "AXI beats extra");
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
